// File: sources.f
hw/csr_pkg.sv
hw/csr_op_decode.sv
hw/csr_trap_regs.sv
hw/csr_timer_irq.sv
hw/csr_read_mux.sv
hw/csr_unit.sv
testbench/csr_unit_checker.sv
testbench/csr_unit_tb.sv

// File: testbench/csr_unit_tb.sv
`default_nettype none

module csr_unit_tb;
    timeunit 1ns;
    timeprecision 1ns;
    import csr_pkg::*;

    typedef struct packed {
        csr_inst_t    pld;
        logic         is_intr;
        logic         msip;
        logic         rdy;
        logic [31:0]  exp_val;
        pc_redirect_t exp_redir;
        logic         exp_vld;
    } row_t;

    logic                 clk;
    logic                 rst_n;
    logic                 instruction_en;
    csr_inst_t            instruction_pld;
    logic                 instruction_is_intr;
    logic                 intr_meip;
    logic                 intr_msip;
    logic                 intr_instruction_rdy;
    logic [phy_reg_w-1:0] reg_index;
    logic                 reg_wr_en;
    logic [xlen-1:0]      reg_val;
    pc_redirect_t         pc_redirect;
    logic                 intr_instruction_vld;

    row_t        table_q[$];
    string       name_q[$];
    logic [31:0] rng_state = 32'd57;
    int unsigned cycle_limit = 1000;
    int unsigned cycle_count = 0;
    int unsigned check_count = 0;
    int unsigned error_count = 0;

    // shadow copies of the CSRs
    logic        m_mie;
    logic        m_mpie;
    logic        m_msie;
    logic        m_mtie;
    logic        m_meie;
    logic        m_sent;
    logic [31:0] m_mtvec;
    logic [31:0] m_mepc;
    logic [31:0] m_mcause;
    logic [31:0] m_mtval;
    logic [31:0] m_mscratch;
    logic [63:0] m_cmp;

    csr_unit dut (
        .clk                  (clk),
        .rst_n                (rst_n),
        .instruction_en       (instruction_en),
        .instruction_pld      (instruction_pld),
        .instruction_is_intr  (instruction_is_intr),
        .intr_meip            (intr_meip),
        .intr_msip            (intr_msip),
        .intr_instruction_rdy (intr_instruction_rdy),
        .reg_index            (reg_index),
        .reg_wr_en            (reg_wr_en),
        .reg_val              (reg_val),
        .pc_redirect          (pc_redirect),
        .intr_instruction_vld (intr_instruction_vld)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: run did not end within %0d cycles", cycle_limit);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    // ======================================================================
    // reference model
    // ======================================================================
    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // count is past zero but far below any other compare used here
    function automatic logic timer_pending();
        return m_cmp == 64'd0;
    endfunction

    function automatic logic [31:0] read_csr(input logic [11:0] addr, input logic msip);
        case (addr)
            csr_mstatus:   return (32'(m_mpie) << 7) | (32'(m_mie) << 3);
            csr_misa:      return misa_rv32i;
            csr_mie:       return (32'(m_meie) << 11) | (32'(m_mtie) << 7) | (32'(m_msie) << 3);
            csr_mtvec:     return m_mtvec;
            csr_mscratch:  return m_mscratch;
            csr_mepc:      return m_mepc;
            csr_mcause:    return m_mcause;
            csr_mtval:     return m_mtval;
            csr_mip:       return (32'(timer_pending()) << 7) | (32'(msip) << 3);
            csr_mtimecmp:  return m_cmp[31:0];
            csr_mtimecmph: return m_cmp[63:32];
            default:       return 32'd0;
        endcase
    endfunction

    function automatic logic [31:0] csr_result(input logic [2:0] f3, input logic [31:0] old_val,
                                               input logic [31:0] opnd);
        case (f3)
            f3_csrrw, f3_csrrwi: return opnd;
            f3_csrrs, f3_csrrsi: return old_val | opnd;
            f3_csrrc, f3_csrrci: return old_val & ~opnd;
            default:             return 32'd0;
        endcase
    endfunction

    task automatic write_csr(input logic [11:0] addr, input logic [31:0] val);
        case (addr)
            csr_mstatus: begin
                m_mie  = val[3];
                m_mpie = val[7];
            end
            csr_mie: begin
                m_msie = val[3];
                m_mtie = val[7];
                m_meie = val[11];
            end
            csr_mtvec: begin
                m_mtvec[31:2] = val[31:2];
                // mode 2 and 3 are reserved
                if (!val[1]) begin
                    m_mtvec[1:0] = val[1:0];
                end
            end
            csr_mscratch:  m_mscratch = val;
            csr_mepc:      m_mepc = val;
            csr_mcause:    m_mcause = val;
            csr_mtval:     m_mtval = val;
            csr_mtimecmp:  m_cmp[31:0] = val;
            csr_mtimecmph: m_cmp[63:32] = val;
            default: ;
        endcase
    endtask

    // one row per instruction with expected values from the model state before it
    task automatic add_row(input string name, input logic [2:0] f3, input logic [11:0] f12,
                           input logic [31:0] opnd, input logic [31:0] pc, input logic rd_en,
                           input logic is_intr, input logic msip, input logic rdy);
        row_t        r;
        logic [31:0] old_val;
        logic [31:0] operand;
        logic [4:0]  field;
        logic        imm_op;
        logic        trap;
        logic        mret;
        logic        pend;
        imm_op  = f3[2];
        field   = imm_op ? opnd[4:0] : 5'd1;
        operand = imm_op ? {27'd0, opnd[4:0]} : opnd;
        r = '0;
        r.pld.inst    = {f12, field, f3, (rd_en ? 5'd5 : 5'd0), 7'h73};
        r.pld.pc      = pc;
        r.pld.rs1_val = imm_op ? ~opnd : opnd;
        r.pld.rd_idx  = 6'(table_q.size());
        r.pld.rd_en   = rd_en;
        r.is_intr     = is_intr;
        r.msip        = msip;
        r.rdy         = rdy;
        old_val       = read_csr(f12, msip);
        r.exp_val     = old_val;
        trap = (f3 == f3_priv) && ((f12 == f12_ecall) || (f12 == f12_ebreak));
        mret = (f3 == f3_priv) && (f12 == f12_mret);
        if (trap || mret) begin
            r.exp_redir.release_en = 1'b1;
            r.exp_redir.update_en  = 1'b1;
            r.exp_redir.target     = trap ? m_mtvec : m_mepc;
        end
        pend      = (m_msie & msip) | (m_mtie & timer_pending());
        r.exp_vld = !m_sent && m_mie && pend;

        // state after the next edge
        if (r.exp_vld && rdy) begin
            m_sent = 1'b1;
        end else if (is_intr) begin
            m_sent = 1'b0;
        end
        if (trap) begin
            m_mepc   = pc;
            m_mtval  = r.pld.inst;
            m_mcause = (f12 == f12_ebreak) ? 32'd3 : 32'd11;
            m_mpie   = m_mie;
            m_mie    = 1'b0;
        end else if (mret) begin
            m_mie  = m_mpie;
            m_mpie = 1'b1;
        end else if (rd_en) begin
            write_csr(f12, csr_result(f3, old_val, operand));
        end
        table_q.push_back(r);
        name_q.push_back(name);
    endtask

    task automatic build_table();
        logic [31:0] pc;
        {m_mie, m_mpie, m_msie, m_mtie, m_meie, m_sent} = '0;
        {m_mtvec, m_mepc, m_mcause, m_mtval, m_mscratch} = '0;
        m_cmp = '0;

        // six operations on mscratch
        add_row("csrrw mscratch", f3_csrrw, csr_mscratch, next_rand(), 0, 1, 0, 0, 0);
        add_row("csrrs mscratch", f3_csrrs, csr_mscratch, next_rand(), 0, 1, 0, 0, 0);
        add_row("csrrc mscratch", f3_csrrc, csr_mscratch, next_rand(), 0, 1, 0, 0, 0);
        add_row("csrrwi mscratch", f3_csrrwi, csr_mscratch, next_rand(), 0, 1, 0, 0, 0);
        add_row("csrrsi mscratch", f3_csrrsi, csr_mscratch, next_rand(), 0, 1, 0, 0, 0);
        add_row("csrrci mscratch", f3_csrrci, csr_mscratch, next_rand(), 0, 1, 0, 0, 0);
        add_row("read mscratch", f3_csrrs, csr_mscratch, 0, 0, 1, 0, 0, 0);

        // mtvec mode bits
        add_row("mtvec vectored", f3_csrrw, csr_mtvec, 32'h0000_1001, 0, 1, 0, 0, 0);
        add_row("mtvec bad mode", f3_csrrw, csr_mtvec, 32'h0000_2003, 0, 1, 0, 0, 0);
        add_row("read mtvec", f3_csrrs, csr_mtvec, 0, 0, 1, 0, 0, 0);

        // ecall, ebreak and mret
        add_row("set mstatus.mie", f3_csrrsi, csr_mstatus, 32'd8, 0, 1, 0, 0, 0);
        pc = next_rand() & ~32'h3;
        add_row("ecall", f3_priv, f12_ecall, 0, pc, 0, 0, 0, 0);
        add_row("mepc after ecall", f3_csrrs, csr_mepc, 0, 0, 1, 0, 0, 0);
        add_row("mtval after ecall", f3_csrrs, csr_mtval, 0, 0, 1, 0, 0, 0);
        add_row("mcause after ecall", f3_csrrs, csr_mcause, 0, 0, 1, 0, 0, 0);
        add_row("mstatus after ecall", f3_csrrs, csr_mstatus, 0, 0, 1, 0, 0, 0);
        add_row("mret", f3_priv, f12_mret, 0, 0, 0, 0, 0, 0);
        add_row("mstatus after mret", f3_csrrs, csr_mstatus, 0, 0, 1, 0, 0, 0);
        pc = next_rand() & ~32'h3;
        add_row("ebreak", f3_priv, f12_ebreak, 0, pc, 0, 0, 0, 0);
        add_row("mcause after ebreak", f3_csrrs, csr_mcause, 0, 0, 1, 0, 0, 0);
        add_row("mepc after ebreak", f3_csrrs, csr_mepc, 0, 0, 1, 0, 0, 0);
        add_row("mstatus after ebreak", f3_csrrs, csr_mstatus, 0, 0, 1, 0, 0, 0);
        add_row("mret again", f3_priv, f12_mret, 0, 0, 0, 0, 0, 0);

        // software interrupt and the handshake
        add_row("enable msie", f3_csrrwi, csr_mie, 32'd8, 0, 1, 0, 0, 0);
        add_row("msip raises vld", f3_csrrs, csr_mip, 0, 0, 1, 0, 1, 0);
        add_row("handshake", f3_csrrs, csr_mip, 0, 0, 1, 0, 1, 1);
        add_row("quiet after accept", f3_csrrs, csr_mip, 0, 0, 1, 0, 1, 0);
        add_row("interrupt instr", f3_priv, 12'h105, 0, 0, 0, 1, 1, 0);
        add_row("vld returns", f3_csrrs, csr_mip, 0, 0, 1, 0, 1, 0);
        add_row("msip released", f3_csrrs, csr_mip, 0, 0, 1, 0, 0, 0);

        // timer compare
        add_row("mtimecmp ones", f3_csrrw, csr_mtimecmp, 32'hffff_ffff, 0, 1, 0, 0, 0);
        add_row("mtimecmph ones", f3_csrrw, csr_mtimecmph, 32'hffff_ffff, 0, 1, 0, 0, 0);
        add_row("enable mtie", f3_csrrw, csr_mie, 32'h0000_0080, 0, 1, 0, 0, 0);
        add_row("timer quiet", f3_csrrs, csr_mip, 0, 0, 1, 0, 0, 0);
        add_row("mtimecmp zero", f3_csrrw, csr_mtimecmp, 0, 0, 1, 0, 0, 0);
        add_row("mtimecmph zero", f3_csrrw, csr_mtimecmph, 0, 0, 1, 0, 0, 0);
        add_row("timer fires", f3_csrrs, csr_mip, 0, 0, 1, 0, 0, 0);
        add_row("read mtimecmph", f3_csrrs, csr_mtimecmph, 0, 0, 1, 0, 0, 0);
    endtask

    // ======================================================================
    // checks
    // ======================================================================
    task automatic check_row(input int i);
        row_t r;
        r = table_q[i];
        check_count += 5;
        assert (reg_wr_en === r.pld.rd_en) else begin
            error_count++;
            $display("FAIL %s reg_wr_en expected %b actual %b", name_q[i], r.pld.rd_en, reg_wr_en);
        end
        assert (reg_index === r.pld.rd_idx) else begin
            error_count++;
            $display("FAIL %s reg_index expected %0d actual %0d", name_q[i], r.pld.rd_idx,
                     reg_index);
        end
        // old value only matters when rd is written
        assert (!r.pld.rd_en || reg_val === r.exp_val) else begin
            error_count++;
            $display("FAIL %s reg_val expected %h actual %h", name_q[i], r.exp_val, reg_val);
        end
        assert (pc_redirect === r.exp_redir) else begin
            error_count++;
            $display("FAIL %s pc_redirect expected %h actual %h", name_q[i], r.exp_redir,
                     pc_redirect);
        end
        assert (intr_instruction_vld === r.exp_vld) else begin
            error_count++;
            $display("FAIL %s vld expected %b actual %b", name_q[i], r.exp_vld,
                     intr_instruction_vld);
        end
    endtask

    initial begin
        rst_n                = 1'b0;
        instruction_en       = 1'b0;
        instruction_pld      = '0;
        instruction_is_intr  = 1'b0;
        intr_meip            = 1'b0;
        intr_msip            = 1'b0;
        intr_instruction_rdy = 1'b0;
        build_table();
        cycle_limit = table_q.size() * 4 + 50;

        repeat (4) @(posedge clk);
        rst_n <= 1'b1;

        foreach (table_q[i]) begin
            @(posedge clk);
            instruction_en       <= 1'b1;
            instruction_pld      <= table_q[i].pld;
            instruction_is_intr  <= table_q[i].is_intr;
            intr_msip            <= table_q[i].msip;
            intr_instruction_rdy <= table_q[i].rdy;
            @(negedge clk);
            check_row(i);
        end

        @(posedge clk);
        instruction_en       <= 1'b0;
        instruction_is_intr  <= 1'b0;
        intr_msip            <= 1'b0;
        intr_instruction_rdy <= 1'b0;
        @(posedge clk);

        $display("checks: %0d  errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/csr_unit_checker.sv
`default_nettype none

module csr_unit_checker (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic                  instruction_en,
    input  wire logic                  instruction_is_intr,
    input  wire logic                  intr_instruction_rdy,
    input  wire csr_pkg::pc_redirect_t pc_redirect,
    input  wire logic                  intr_instruction_vld
);
    timeunit 1ns;
    timeprecision 1ns;

    // release and update always travel together
    redirect_pair: assert property (@(posedge clk) disable iff (!rst_n)
        pc_redirect.update_en == pc_redirect.release_en)
        else $error("redirect update and release differ");

    // no target without a redirect
    redirect_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !pc_redirect.update_en |-> pc_redirect.target == '0)
        else $error("redirect target not zero while idle");

    // a taken request stays quiet the next cycle
    vld_after_handshake: assert property (@(posedge clk) disable iff (!rst_n)
        (intr_instruction_vld && intr_instruction_rdy) |=> !intr_instruction_vld)
        else $error("interrupt request raised right after a handshake");

    // no new request until the interrupt instruction arrives
    vld_until_intr: assert property (@(posedge clk) disable iff (!rst_n)
        (intr_instruction_vld && intr_instruction_rdy) ##1
        !(instruction_en && instruction_is_intr) |=> !intr_instruction_vld)
        else $error("interrupt request raised before the interrupt instruction");

endmodule

bind csr_unit csr_unit_checker u_checker (.*);

`default_nettype wire

// File: hw/csr_unit.sv
`default_nettype none

module csr_unit (
    input  wire logic                          clk,
    input  wire logic                          rst_n,
    input  wire logic                          instruction_en,
    input  wire csr_pkg::csr_inst_t            instruction_pld,
    input  wire logic                          instruction_is_intr,
    input  wire logic                          intr_meip,
    input  wire logic                          intr_msip,
    input  wire logic                          intr_instruction_rdy,
    output logic [csr_pkg::phy_reg_w-1:0]      reg_index,
    output logic                               reg_wr_en,
    output logic [csr_pkg::xlen-1:0]           reg_val,
    output csr_pkg::pc_redirect_t              pc_redirect,
    output logic                               intr_instruction_vld
);
    import csr_pkg::*;

    csr_ctl_t        ctl;
    logic [xlen-1:0] rdata;
    mstatus_t        mstatus;
    logic [xlen-1:0] mtvec;
    logic [xlen-1:0] mepc;
    logic [xlen-1:0] mcause;
    logic [xlen-1:0] mtval;
    logic [xlen-1:0] mscratch;
    logic [63:0]     cycle;
    logic [63:0]     mtimecmp;
    mie_t            mie;
    mip_t            mip;

    csr_op_decode u_decode (
        .instruction_en (instruction_en),
        .inst           (instruction_pld),
        .rdata          (rdata),
        .ctl            (ctl)
    );

    csr_trap_regs u_trap_regs (
        .clk         (clk),
        .rst_n       (rst_n),
        .ctl         (ctl),
        .inst        (instruction_pld),
        .mstatus     (mstatus),
        .mtvec       (mtvec),
        .mepc        (mepc),
        .mcause      (mcause),
        .mtval       (mtval),
        .mscratch    (mscratch),
        .pc_redirect (pc_redirect)
    );

    csr_timer_irq u_timer_irq (
        .clk                  (clk),
        .rst_n                (rst_n),
        .ctl                  (ctl),
        .mstatus_mie          (mstatus.mie),
        .instruction_en       (instruction_en),
        .instruction_is_intr  (instruction_is_intr),
        .intr_meip            (intr_meip),
        .intr_msip            (intr_msip),
        .intr_instruction_rdy (intr_instruction_rdy),
        .cycle                (cycle),
        .mtimecmp             (mtimecmp),
        .mie                  (mie),
        .mip                  (mip),
        .intr_instruction_vld (intr_instruction_vld)
    );

    // old value goes to rd and back into the set/clear logic
    csr_read_mux u_read_mux (
        .addr     (ctl.addr),
        .mstatus  (mstatus),
        .mtvec    (mtvec),
        .mepc     (mepc),
        .mcause   (mcause),
        .mtval    (mtval),
        .mscratch (mscratch),
        .cycle    (cycle),
        .mtimecmp (mtimecmp),
        .mie      (mie),
        .mip      (mip),
        .rdata    (rdata)
    );

    assign reg_index = instruction_pld.rd_idx;
    assign reg_val   = rdata;
    assign reg_wr_en = ctl.wr_en;

endmodule

`default_nettype wire

// File: hw/csr_read_mux.sv
`default_nettype none

module csr_read_mux (
    input  wire logic [csr_pkg::csr_addr_w-1:0] addr,
    input  wire csr_pkg::mstatus_t              mstatus,
    input  wire logic [csr_pkg::xlen-1:0]       mtvec,
    input  wire logic [csr_pkg::xlen-1:0]       mepc,
    input  wire logic [csr_pkg::xlen-1:0]       mcause,
    input  wire logic [csr_pkg::xlen-1:0]       mtval,
    input  wire logic [csr_pkg::xlen-1:0]       mscratch,
    input  wire logic [63:0]                    cycle,
    input  wire logic [63:0]                    mtimecmp,
    input  wire csr_pkg::mie_t                  mie,
    input  wire csr_pkg::mip_t                  mip,
    output logic [csr_pkg::xlen-1:0]            rdata
);
    import csr_pkg::*;

    always_comb begin
        case (addr)
            // ==============================================================
            // trap setup and handling
            // ==============================================================
            csr_mstatus:   rdata = mstatus;
            csr_misa:      rdata = misa_rv32i;
            csr_mie:       rdata = mie;
            csr_mtvec:     rdata = mtvec;
            csr_mscratch:  rdata = mscratch;
            csr_mepc:      rdata = mepc;
            csr_mcause:    rdata = mcause;
            csr_mtval:     rdata = mtval;
            csr_mip:       rdata = mip;

            // ==============================================================
            // user and machine counter views read one counter
            // ==============================================================
            csr_mcycle,
            csr_cycle:     rdata = cycle[31:0];
            csr_mcycleh,
            csr_cycleh:    rdata = cycle[63:32];
            csr_mtimecmp:  rdata = mtimecmp[31:0];
            csr_mtimecmph: rdata = mtimecmp[63:32];

            default:       rdata = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: hw/csr_timer_irq.sv
`default_nettype none

module csr_timer_irq (
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire csr_pkg::csr_ctl_t  ctl,
    input  wire logic               mstatus_mie,
    input  wire logic               instruction_en,
    input  wire logic               instruction_is_intr,
    input  wire logic               intr_meip,
    input  wire logic               intr_msip,
    input  wire logic               intr_instruction_rdy,
    output logic [63:0]             cycle,
    output logic [63:0]             mtimecmp,
    output csr_pkg::mie_t           mie,
    output csr_pkg::mip_t           mip,
    output logic                    intr_instruction_vld
);
    import csr_pkg::*;

    logic msie_q;
    logic mtie_q;
    logic meie_q;
    logic intr_sent;
    logic intr_pending;

    // ======================================================================
    // cycle counter and timer compare
    // ======================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cycle <= '0;
        end else begin
            cycle <= cycle + 64'd1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtimecmp <= '0;
        end else if (ctl.wr_en) begin
            if (ctl.addr == csr_mtimecmp)  mtimecmp[31:0]  <= ctl.wdata.raw;
            if (ctl.addr == csr_mtimecmph) mtimecmp[63:32] <= ctl.wdata.raw;
        end
    end

    // ======================================================================
    // enable and pending bits
    // ======================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            msie_q <= 1'b0;
            mtie_q <= 1'b0;
            meie_q <= 1'b0;
        end else if (ctl.wr_en && ctl.addr == csr_mie) begin
            msie_q <= ctl.wdata.mie.msie;
            mtie_q <= ctl.wdata.mie.mtie;
            meie_q <= ctl.wdata.mie.meie;
        end
    end

    always_comb begin
        mie      = '0;
        mie.msie = msie_q;
        mie.mtie = mtie_q;
        mie.meie = meie_q;

        // pins pass straight through, timer from the compare
        mip      = '0;
        mip.msip = intr_msip;
        mip.mtip = (cycle > mtimecmp);
        mip.meip = intr_meip;
    end

    // request is silent from the handshake until the interrupt instruction
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            intr_sent <= 1'b0;
        end else if (intr_instruction_vld && intr_instruction_rdy) begin
            intr_sent <= 1'b1;
        end else if (instruction_en && instruction_is_intr) begin
            intr_sent <= 1'b0;
        end
    end

    assign intr_pending = (mie.msie & mip.msip) |
                          (mie.mtie & mip.mtip) |
                          (mie.meie & mip.meip);

    assign intr_instruction_vld = ~intr_sent & mstatus_mie & intr_pending;

endmodule

`default_nettype wire

// File: hw/csr_trap_regs.sv
`default_nettype none

module csr_trap_regs (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  wire csr_pkg::csr_ctl_t        ctl,
    input  wire csr_pkg::csr_inst_t       inst,
    output csr_pkg::mstatus_t             mstatus,
    output logic [csr_pkg::xlen-1:0]      mtvec,
    output logic [csr_pkg::xlen-1:0]      mepc,
    output logic [csr_pkg::xlen-1:0]      mcause,
    output logic [csr_pkg::xlen-1:0]      mtval,
    output logic [csr_pkg::xlen-1:0]      mscratch,
    output csr_pkg::pc_redirect_t         pc_redirect
);
    import csr_pkg::*;

    logic mie_q;
    logic mpie_q;

    // ======================================================================
    // mstatus interrupt-enable stack
    // ======================================================================
    // trap wins over mret, mret over a plain write
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mie_q  <= 1'b0;
            mpie_q <= 1'b0;
        end else if (ctl.trap_en) begin
            mie_q  <= 1'b0;
            mpie_q <= mie_q;
        end else if (ctl.mret_en) begin
            mie_q  <= mpie_q;
            mpie_q <= 1'b1;
        end else if (ctl.wr_en && ctl.addr == csr_mstatus) begin
            mie_q  <= ctl.wdata.mstatus.mie;
            mpie_q <= ctl.wdata.mstatus.mpie;
        end
    end

    always_comb begin
        mstatus      = '0;
        mstatus.mie  = mie_q;
        mstatus.mpie = mpie_q;
    end

    // ======================================================================
    // trap setup and handling registers
    // ======================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtvec    <= '0;
            mscratch <= '0;
        end else if (ctl.wr_en) begin
            if (ctl.addr == csr_mtvec) begin
                mtvec[xlen-1:2] <= ctl.wdata.raw[xlen-1:2];
                // only direct and vectored modes are legal
                if (!ctl.wdata.raw[1]) begin
                    mtvec[1:0] <= ctl.wdata.raw[1:0];
                end
            end
            if (ctl.addr == csr_mscratch) begin
                mscratch <= ctl.wdata.raw;
            end
        end
    end

    // state saved on ecall / ebreak
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mepc   <= '0;
            mcause <= '0;
            mtval  <= '0;
        end else if (ctl.trap_en) begin
            mepc   <= inst.pc;
            mtval  <= inst.inst;
            mcause <= ctl.cause ? mcause_break : mcause_ecall_m;
        end else if (ctl.wr_en) begin
            if (ctl.addr == csr_mepc)   mepc   <= ctl.wdata.raw;
            if (ctl.addr == csr_mcause) mcause <= ctl.wdata.raw;
            if (ctl.addr == csr_mtval)  mtval  <= ctl.wdata.raw;
        end
    end

    // ======================================================================
    // pc redirect
    // ======================================================================
    always_comb begin
        pc_redirect = '0;
        if (ctl.trap_en) begin
            pc_redirect.release_en = 1'b1;
            pc_redirect.update_en  = 1'b1;
            pc_redirect.target     = mtvec;
        end else if (ctl.mret_en) begin
            pc_redirect.release_en = 1'b1;
            pc_redirect.update_en  = 1'b1;
            pc_redirect.target     = mepc;
        end
    end

endmodule

`default_nettype wire

// File: hw/csr_op_decode.sv
`default_nettype none

module csr_op_decode (
    input  wire logic                      instruction_en,
    input  wire csr_pkg::csr_inst_t        inst,
    input  wire logic [csr_pkg::xlen-1:0]  rdata,
    output csr_pkg::csr_ctl_t              ctl
);
    import csr_pkg::*;

    logic [2:0]      funct3;
    logic [11:0]     funct12;
    logic [4:0]      uimm;
    logic [xlen-1:0] uimm_ext;
    logic            is_priv;

    // SYSTEM instruction fields
    assign funct3   = inst.inst[14:12];
    assign funct12  = inst.inst[31:20];
    assign uimm     = inst.inst[19:15];
    assign uimm_ext = {{(xlen-5){1'b0}}, uimm};
    assign is_priv  = (funct3 == f3_priv);

    always_comb begin
        ctl = '0;
        ctl.addr = funct12;

        // new value from the old one and the operand
        case (funct3)
            f3_csrrw:  ctl.wdata.raw = inst.rs1_val;
            f3_csrrs:  ctl.wdata.raw = rdata | inst.rs1_val;
            f3_csrrc:  ctl.wdata.raw = rdata & ~inst.rs1_val;
            f3_csrrwi: ctl.wdata.raw = uimm_ext;
            f3_csrrsi: ctl.wdata.raw = rdata | uimm_ext;
            f3_csrrci: ctl.wdata.raw = rdata & ~uimm_ext;
            default:   ctl.wdata.raw = '0;
        endcase

        ctl.wr_en = instruction_en & inst.rd_en;

        // ecall / ebreak / mret
        if (is_priv && ((funct12 == f12_ecall) || (funct12 == f12_ebreak))) begin
            ctl.trap_en = instruction_en;
        end
        if (is_priv && (funct12 == f12_mret)) begin
            ctl.mret_en = instruction_en;
        end
        ctl.cause = (funct12 == f12_ebreak);
    end

endmodule

`default_nettype wire

// File: hw/csr_pkg.sv
`default_nettype none

package csr_pkg;

    // ======================================================================
    // widths
    // ======================================================================
    localparam int xlen       = 32;
    localparam int phy_reg_w  = 6;
    localparam int csr_addr_w = 12;

    // funct3 of the SYSTEM opcode
    localparam logic [2:0] f3_priv   = 3'b000;
    localparam logic [2:0] f3_csrrw  = 3'b001;
    localparam logic [2:0] f3_csrrs  = 3'b010;
    localparam logic [2:0] f3_csrrc  = 3'b011;
    localparam logic [2:0] f3_csrrwi = 3'b101;
    localparam logic [2:0] f3_csrrsi = 3'b110;
    localparam logic [2:0] f3_csrrci = 3'b111;

    // funct12 when funct3 is f3_priv
    localparam logic [11:0] f12_ecall  = 12'h000;
    localparam logic [11:0] f12_ebreak = 12'h001;
    localparam logic [11:0] f12_mret   = 12'h302;

    localparam logic [31:0] mcause_ecall_m = 32'd11;
    localparam logic [31:0] mcause_break   = 32'd3;

    // ======================================================================
    // csr addresses
    // ======================================================================
    localparam logic [11:0] csr_mstatus  = 12'h300;
    localparam logic [11:0] csr_misa     = 12'h301;
    localparam logic [11:0] csr_mie      = 12'h304;
    localparam logic [11:0] csr_mtvec    = 12'h305;
    localparam logic [11:0] csr_mscratch = 12'h340;
    localparam logic [11:0] csr_mepc     = 12'h341;
    localparam logic [11:0] csr_mcause   = 12'h342;
    localparam logic [11:0] csr_mtval    = 12'h343;
    localparam logic [11:0] csr_mip      = 12'h344;
    localparam logic [11:0] csr_mcycle   = 12'hb00;
    localparam logic [11:0] csr_mcycleh  = 12'hb80;
    localparam logic [11:0] csr_cycle    = 12'hc00;
    localparam logic [11:0] csr_cycleh   = 12'hc80;
    // custom machine read-write range
    localparam logic [11:0] csr_mtimecmp  = 12'h7c0;
    localparam logic [11:0] csr_mtimecmph = 12'h7c1;

    // mxl = 1, extension I
    localparam logic [31:0] misa_rv32i = 32'h4000_0100;

    // ======================================================================
    // register types
    // ======================================================================
    typedef struct packed {
        logic [23:0] rsv_31_8;
        logic        mpie;
        logic [2:0]  rsv_6_4;
        logic        mie;
        logic [2:0]  rsv_2_0;
    } mstatus_t;

    typedef struct packed {
        logic [19:0] rsv_31_12;
        logic        meie;
        logic [2:0]  rsv_10_8;
        logic        mtie;
        logic [2:0]  rsv_6_4;
        logic        msie;
        logic [2:0]  rsv_2_0;
    } mie_t;

    typedef struct packed {
        logic [19:0] rsv_31_12;
        logic        meip;
        logic [2:0]  rsv_10_8;
        logic        mtip;
        logic [2:0]  rsv_6_4;
        logic        msip;
        logic [2:0]  rsv_2_0;
    } mip_t;

    // write data seen through the register it targets
    typedef union packed {
        logic [xlen-1:0] raw;
        mstatus_t        mstatus;
        mie_t            mie;
    } csr_word_u;

    typedef struct packed {
        logic [31:0]          inst;
        logic [xlen-1:0]      pc;
        logic [xlen-1:0]      rs1_val;
        logic [phy_reg_w-1:0] rd_idx;
        logic                 rd_en;
    } csr_inst_t;

    typedef struct packed {
        csr_word_u             wdata;
        logic [csr_addr_w-1:0] addr;
        logic                  wr_en;
        logic                  trap_en;
        logic                  mret_en;
        logic                  cause;    // 1 for ebreak
    } csr_ctl_t;

    typedef struct packed {
        logic            release_en;
        logic            update_en;
        logic [xlen-1:0] target;
    } pc_redirect_t;

endpackage

`default_nettype wire
